// File: verilog.f
+incdir+source
source/hwce_cfg_pkg.sv
source/hwce_data_pkg.sv
source/hwce_regfile.sv
source/hwce_ctrl.sv
source/hwce_weight_loader.sv
source/hwce_window.sv
source/hwce_sop.sv
source/hwce_top.sv
tb/tb_hwce_top.sv

// File: Bender.yml
package:
  name: hwce_stream

sources:
  - include_dirs:
      - source
    files:
      - source/hwce_cfg_pkg.sv
      - source/hwce_data_pkg.sv
      - source/hwce_regfile.sv
      - source/hwce_ctrl.sv
      - source/hwce_weight_loader.sv
      - source/hwce_window.sv
      - source/hwce_sop.sv
      - source/hwce_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/tb_hwce_top.sv

// File: tb/tb_hwce_top.sv
//////////////////////////////////////////////////////////////////////
// testbench for the convolution engine top level
// clock, reset, weight memory model, stream drivers,
// reference model and checking assertions
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "hwce_defines.svh"

module tb_hwce_top;
  import hwce_cfg_pkg::*;
  import hwce_data_pkg::*;

  localparam int NUM_JOBS    = 5;
  localparam int MAX_LEN     = 40;
  localparam int CYCLE_LIMIT = 200 * NUM_JOBS + MAX_LEN * 8;

  logic                    clk_fast_i    = 1'b0;
  logic                    rst_n         = 1'b0;
  logic                    cfg_req_i     = 1'b0;
  cfg_req_t                cfg_req_data_i = '0;
  logic                    cfg_gnt_o;
  logic                    cfg_r_valid_o;
  cfg_rsp_t                cfg_rsp_o;
  logic                    mem_req_o;
  logic                    mem_gnt_i     = 1'b0;
  mem_addr_t               mem_addr_o;
  logic                    mem_r_valid_i = 1'b0;
  logic [`HWCE_DATA_W-1:0] mem_rdata_i   = '0;
  logic                    x_in_valid_i  = 1'b0;
  pixel_t                  x_in_i        = '0;
  logic                    x_in_ready_o;
  logic                    y_in_valid_i  = 1'b0;
  pixel_t                  y_in_i        = '0;
  logic                    y_in_ready_o;
  logic                    y_out_valid_o;
  pixel_t                  y_out_o;
  logic                    y_out_ready_i = 1'b0;
  logic                    evt_interrupt_o;

  // job description and reference data
  weight_t   taps [`HWCE_TAPS];
  pixel_t    bias;
  pixel_t    x_arr [MAX_LEN];
  pixel_t    y_arr [MAX_LEN];
  pixel_t    exp_arr [MAX_LEN];
  mem_addr_t job_base = '0;
  int        job_len  = 0;
  int        n_out    = 0;
  int        job_qf   = 0;
  bit        job_relu = 1'b0;
  bit        rand_rdy = 1'b0;
  bit        streams_on = 1'b0;
  bit        clear_cnt  = 1'b0;

  // weight memory indexed by word address bits 9:2
  logic [`HWCE_DATA_W-1:0] mem_words [256];
  logic [7:0]              pend_q [$];

  // progress counters updated on the rising edge
  int   x_sent  = 0;
  int   y_sent  = 0;
  int   out_idx = 0;
  int   gnt_cnt = 0;
  int   rsp_cnt = 0;
  int   evt_cnt = 0;
  logic x_took  = 1'b0;
  logic y_took  = 1'b0;

  logic        rd_check = 1'b0;
  logic [31:0] rd_value = '0;
  logic [7:0]  next_id  = 8'h10;
  int          err_cnt  = 0;
  int          test_cnt = 0;
  int          cycle_cnt = 0;
  logic        out_fire;
  pixel_t      exp_y;

  assign out_fire = y_out_valid_o & y_out_ready_i;
  assign exp_y    = exp_arr[out_idx];

  always #5 clk_fast_i = ~clk_fast_i;

  hwce_top hwce_top_inst (.*);

  //////////////////////////////////////////////////////////////////////
  // memory model and stream drivers on the falling edge
  //////////////////////////////////////////////////////////////////////
  always @(negedge clk_fast_i) begin
    // only grants from earlier cycles can answer
    mem_r_valid_i = 1'b0;
    if (pend_q.size() > 0 && ($urandom % 3) != 0) begin
      mem_r_valid_i = 1'b1;
      mem_rdata_i   = mem_words[pend_q.pop_front()];
    end
    mem_gnt_i = (($urandom % 3) != 0);
    if (rst_n && mem_req_o && mem_gnt_i) begin
      pend_q.push_back(mem_addr_o[9:2]);
    end
  end

  always @(negedge clk_fast_i) begin
    if (!streams_on) begin
      x_in_valid_i = 1'b0;
      y_in_valid_i = 1'b0;
    end else begin
      // a beat stays put until it is taken
      if (!x_in_valid_i || x_took) begin
        x_in_valid_i = (x_sent < job_len) && (($urandom % 4) != 0);
        x_in_i       = x_arr[x_sent];
      end
      if (!y_in_valid_i || y_took) begin
        y_in_valid_i = (y_sent < n_out) && (($urandom % 4) != 0);
        y_in_i       = y_arr[y_sent];
      end
    end
    y_out_ready_i = rand_rdy ? 1'($urandom % 2) : 1'b1;
  end

  always @(posedge clk_fast_i) begin
    if (clear_cnt) begin
      x_sent  <= 0;
      y_sent  <= 0;
      out_idx <= 0;
      gnt_cnt <= 0;
      rsp_cnt <= 0;
      evt_cnt <= 0;
      x_took  <= 1'b0;
      y_took  <= 1'b0;
    end else begin
      x_took  <= x_in_valid_i & x_in_ready_o;
      y_took  <= y_in_valid_i & y_in_ready_o;
      x_sent  <= x_sent + int'(x_in_valid_i & x_in_ready_o);
      y_sent  <= y_sent + int'(y_in_valid_i & y_in_ready_o);
      out_idx <= out_idx + int'(out_fire);
      gnt_cnt <= gnt_cnt + int'(mem_req_o & mem_gnt_i);
      rsp_cnt <= rsp_cnt + int'(mem_r_valid_i);
      evt_cnt <= evt_cnt + int'(evt_interrupt_o);
    end
  end

  always @(posedge clk_fast_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not complete within %0d cycles", CYCLE_LIMIT);
      $display("Finished with errors");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////
  a_cfg_gnt : assert property (@(posedge clk_fast_i) disable iff (!rst_n)
    cfg_gnt_o == cfg_req_i)
    else report_error("configuration grant does not follow the request");

  a_cfg_rsp_id : assert property (@(posedge clk_fast_i) disable iff (!rst_n)
    cfg_req_i |=> cfg_r_valid_o && cfg_rsp_o.id == $past(cfg_req_data_i.id))
    else report_error("configuration response missing or with a wrong ID");

  a_cfg_no_extra : assert property (@(posedge clk_fast_i) disable iff (!rst_n)
    cfg_r_valid_o |-> $past(cfg_req_i))
    else report_error("configuration response without a request");

  a_cfg_rdata : assert property (@(posedge clk_fast_i) disable iff (!rst_n)
    cfg_req_i && rd_check |=> cfg_rsp_o.rdata == $past(rd_value))
    else report_error($sformatf("register read %0h, expected %0h",
                                $sampled(cfg_rsp_o.rdata), $past(rd_value)));

  a_mem_addr : assert property (@(posedge clk_fast_i) disable iff (!rst_n)
    mem_req_o && mem_gnt_i |-> gnt_cnt < 6 && mem_addr_o == job_base + 32'(gnt_cnt * 4))
    else report_error($sformatf("memory request %0d at address %0h",
                                $sampled(gnt_cnt), $sampled(mem_addr_o)));

  a_mem_hold : assert property (@(posedge clk_fast_i) disable iff (!rst_n)
    mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_addr_o))
    else report_error("memory request dropped or changed before its grant");

  a_streams_after_load : assert property (@(posedge clk_fast_i) disable iff (!rst_n)
    x_in_ready_o || y_in_ready_o |-> rsp_cnt == 6)
    else report_error("stream accepted before all weights arrived");

  a_out_value : assert property (@(posedge clk_fast_i) disable iff (!rst_n)
    out_fire |-> out_idx < n_out && y_out_o == exp_y)
    else report_error($sformatf("y_out %0d, expected %0d at output %0d",
                                $sampled(y_out_o), $sampled(exp_y), $sampled(out_idx)));

  a_out_relu : assert property (@(posedge clk_fast_i) disable iff (!rst_n)
    out_fire && job_relu |-> !y_out_o[`HWCE_PIX_W-1])
    else report_error("negative y_out with the rectifier on");

  a_out_stable : assert property (@(posedge clk_fast_i) disable iff (!rst_n)
    y_out_valid_o && !y_out_ready_i |=> y_out_valid_o && $stable(y_out_o))
    else report_error("y_out changed while stalled");

  a_evt_after_last : assert property (@(posedge clk_fast_i) disable iff (!rst_n)
    out_fire && out_idx == n_out - 1 |=> evt_interrupt_o ##1 !evt_interrupt_o)
    else report_error("event pulse missing or too long after the last output");

  a_evt_cause : assert property (@(posedge clk_fast_i) disable iff (!rst_n)
    evt_interrupt_o |-> $past(out_fire) && $past(out_idx) == n_out - 1)
    else report_error("event pulse without a final output");

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////
  task automatic report_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    err_cnt++;
  endtask

  function automatic int rand_between(input int lo, input int hi);
    return lo + int'($urandom % (hi - lo + 1));
  endfunction

  // convolution rule evaluated on wide integers
  function automatic pixel_t expected_output(input int k);
    longint acc;
    acc = 0;
    for (int j = 0; j < `HWCE_TAPS; j++) begin
      acc = acc + longint'(taps[j]) * longint'(x_arr[k + j]);
    end
    acc = acc + (longint'(y_arr[k]) <<< job_qf) + (longint'(bias) <<< job_qf);
    acc = acc >>> job_qf;
    if (acc > 32767) begin
      acc = 32767;
    end else if (acc < -32768) begin
      acc = -32768;
    end
    if (job_relu && acc < 0) begin
      acc = 0;
    end
    return pixel_t'(acc);
  endfunction

  task automatic cfg_access(input logic we, input logic [2:0] idx, input logic [31:0] wdata,
                            input logic check, input logic [31:0] value);
    @(negedge clk_fast_i);
    cfg_req_i            = 1'b1;
    cfg_req_data_i.addr  = {27'd0, idx, 2'b00};
    cfg_req_data_i.we    = we;
    cfg_req_data_i.wdata = wdata;
    cfg_req_data_i.id    = next_id;
    rd_check             = check;
    rd_value             = value;
    next_id              = next_id + 8'd3;
    @(negedge clk_fast_i);
    cfg_req_i = 1'b0;
    rd_check  = 1'b0;
  endtask

  task automatic reg_write(input logic [2:0] idx, input logic [31:0] wdata);
    cfg_access(1'b1, idx, wdata, 1'b1, 32'd0);
  endtask

  task automatic reg_read(input logic [2:0] idx, input logic [31:0] value);
    cfg_access(1'b0, idx, 32'd0, 1'b1, value);
  endtask

  task automatic check_registers();
    int errs_before;
    errs_before = err_cnt;
    reg_read(`HWCE_REG_STATUS, 32'd0);
    reg_write(`HWCE_REG_WBASE, 32'h1234_5678);
    reg_write(`HWCE_REG_XLEN, 32'h0000_beef);
    reg_write(`HWCE_REG_QF, 32'h0000_0029);
    reg_write(`HWCE_REG_FLAGS, 32'h0000_0003);
    reg_read(`HWCE_REG_WBASE, 32'h1234_5678);
    reg_read(`HWCE_REG_XLEN, 32'h0000_beef);
    reg_read(`HWCE_REG_QF, 32'h0000_0009);
    reg_read(`HWCE_REG_FLAGS, 32'h0000_0001);
    reg_read(`HWCE_REG_STATUS, 32'd0);
    test_cnt++;
    $display("test registers: %0d errors", err_cnt - errs_before);
  endtask

  // weight words, random streams and expected outputs
  task automatic build_job(input int len, input int qf, input bit relu,
                           input int tap_mag, input int pix_mag);
    job_len  = len;
    n_out    = len - 4;
    job_qf   = qf;
    job_relu = relu;
    job_base = 32'h4000_0100 + 32'(test_cnt * 64);
    for (int k = 0; k < `HWCE_TAPS; k++) begin
      taps[k] = weight_t'(rand_between(-tap_mag, tap_mag - 1));
      mem_words[job_base[9:2] + k] = {16'($urandom), taps[k]};
    end
    bias = pixel_t'(rand_between(-pix_mag, pix_mag - 1));
    mem_words[job_base[9:2] + 5] = {16'($urandom), bias};
    for (int k = 0; k < len; k++) begin
      x_arr[k] = pixel_t'(rand_between(-pix_mag, pix_mag - 1));
      y_arr[k] = pixel_t'(rand_between(-pix_mag, pix_mag - 1));
    end
    for (int k = 0; k < n_out; k++) begin
      exp_arr[k] = expected_output(k);
    end
  endtask

  task automatic run_job(input string name, input int len, input int qf, input bit relu,
                         input int tap_mag, input int pix_mag, input bit stall,
                         input bit busy_write);
    int errs_before;
    errs_before = err_cnt;
    build_job(len, qf, relu, tap_mag, pix_mag);
    rand_rdy = stall;
    @(negedge clk_fast_i);
    clear_cnt = 1'b1;
    @(negedge clk_fast_i);
    clear_cnt = 1'b0;
    reg_write(`HWCE_REG_WBASE, job_base);
    reg_write(`HWCE_REG_XLEN, 32'(len));
    reg_write(`HWCE_REG_QF, 32'(qf));
    reg_write(`HWCE_REG_FLAGS, 32'(relu));
    streams_on = 1'b1;
    reg_write(`HWCE_REG_TRIGGER, 32'd1);
    reg_read(`HWCE_REG_STATUS, 32'd1);
    if (busy_write) begin
      reg_write(`HWCE_REG_XLEN, 32'(len + 18));
      reg_read(`HWCE_REG_XLEN, 32'(len));
    end
    while (evt_cnt == 0) begin
      @(negedge clk_fast_i);
    end
    streams_on = 1'b0;
    repeat (3) @(negedge clk_fast_i);
    assert (gnt_cnt == 6 && rsp_cnt == 6)
      else report_error($sformatf("%0d weight requests granted", gnt_cnt));
    assert (x_sent == job_len && y_sent == n_out)
      else report_error($sformatf("streams took %0d x and %0d y beats", x_sent, y_sent));
    assert (out_idx == n_out)
      else report_error($sformatf("%0d outputs, expected %0d", out_idx, n_out));
    assert (evt_cnt == 1)
      else report_error($sformatf("%0d event pulses", evt_cnt));
    reg_read(`HWCE_REG_STATUS, 32'd0);
    reg_read(`HWCE_REG_XLEN, 32'(len));
    test_cnt++;
    $display("test %s: %0d errors", name, err_cnt - errs_before);
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    void'($urandom(32'hbfa9_ebfe));
    for (int i = 0; i < 256; i++) begin
      mem_words[i] = 32'(i) * 32'h9e37_79b1;
    end
    repeat (4) @(negedge clk_fast_i);
    rst_n = 1'b1;
    check_registers();
    run_job("convolution", 24, 4, 1'b0, 64, 128, 1'b0, 1'b0);
    run_job("saturation", 16, 0, 1'b0, 30000, 30000, 1'b0, 1'b0);
    run_job("rectifier", 20, 2, 1'b1, 64, 256, 1'b0, 1'b0);
    run_job("back-pressure", MAX_LEN, 3, 1'b0, 64, 128, 1'b1, 1'b0);
    run_job("busy", 12, 1, 1'b0, 64, 128, 1'b0, 1'b1);
    $display("%0d tests run, %0d errors", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: source/hwce_top.sv
//////////////////////////////////////////////////////////////////////
// convolution engine top level
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "hwce_defines.svh"

module hwce_top (
  input  logic                     clk_fast_i,
  input  logic                     rst_n,
  // configuration port
  input  logic                     cfg_req_i,
  output logic                     cfg_gnt_o,
  input  hwce_cfg_pkg::cfg_req_t   cfg_req_data_i,
  output logic                     cfg_r_valid_o,
  output hwce_cfg_pkg::cfg_rsp_t   cfg_rsp_o,
  // weight memory port
  output logic                     mem_req_o,
  input  logic                     mem_gnt_i,
  output hwce_data_pkg::mem_addr_t mem_addr_o,
  input  logic                     mem_r_valid_i,
  input  logic [`HWCE_DATA_W-1:0]  mem_rdata_i,
  // pixel streams
  input  logic                     x_in_valid_i,
  input  hwce_data_pkg::pixel_t    x_in_i,
  output logic                     x_in_ready_o,
  input  logic                     y_in_valid_i,
  input  hwce_data_pkg::pixel_t    y_in_i,
  output logic                     y_in_ready_o,
  output logic                     y_out_valid_o,
  output hwce_data_pkg::pixel_t    y_out_o,
  input  logic                     y_out_ready_i,
  output logic                     evt_interrupt_o
);
  import hwce_cfg_pkg::*;
  import hwce_data_pkg::*;

  job_params_t params;
  weight_set_t weights;
  window_t     win;
  logic        trigger;
  logic        busy;
  logic        wl_start;
  logic        wl_done;
  logic        compute;
  logic        win_valid;
  logic        win_ready;
  logic        out_fire;

  assign out_fire = y_out_valid_o & y_out_ready_i;

  hwce_regfile regfile_inst (
    .clk_fast_i     (clk_fast_i),
    .rst_n          (rst_n),
    .cfg_req_i      (cfg_req_i),
    .cfg_req_data_i (cfg_req_data_i),
    .busy_i         (busy),
    .cfg_gnt_o      (cfg_gnt_o),
    .cfg_r_valid_o  (cfg_r_valid_o),
    .cfg_rsp_o      (cfg_rsp_o),
    .params_o       (params),
    .trigger_o      (trigger)
  );

  hwce_ctrl ctrl_inst (
    .clk_fast_i      (clk_fast_i),
    .rst_n           (rst_n),
    .trigger_i       (trigger),
    .wl_done_i       (wl_done),
    .out_fire_i      (out_fire),
    .x_len_i         (params.x_len),
    .wl_start_o      (wl_start),
    .compute_o       (compute),
    .busy_o          (busy),
    .evt_interrupt_o (evt_interrupt_o)
  );

  hwce_weight_loader weight_loader_inst (
    .clk_fast_i    (clk_fast_i),
    .rst_n         (rst_n),
    .start_i       (wl_start),
    .base_i        (params.wbase),
    .mem_gnt_i     (mem_gnt_i),
    .mem_r_valid_i (mem_r_valid_i),
    .mem_rdata_i   (mem_rdata_i),
    .mem_req_o     (mem_req_o),
    .mem_addr_o    (mem_addr_o),
    .weights_o     (weights),
    .done_o        (wl_done)
  );

  // window is cleared at job start, streams open in COMPUTE
  hwce_window window_inst (
    .clk_fast_i   (clk_fast_i),
    .rst_n        (rst_n),
    .start_i      (wl_start),
    .enable_i     (compute),
    .x_in_valid_i (x_in_valid_i),
    .x_in_i       (x_in_i),
    .y_in_valid_i (y_in_valid_i),
    .y_in_i       (y_in_i),
    .win_ready_i  (win_ready),
    .x_in_ready_o (x_in_ready_o),
    .y_in_ready_o (y_in_ready_o),
    .win_valid_o  (win_valid),
    .win_o        (win)
  );

  hwce_sop sop_inst (
    .clk_fast_i    (clk_fast_i),
    .rst_n         (rst_n),
    .win_valid_i   (win_valid),
    .win_i         (win),
    .weights_i     (weights),
    .qf_i          (params.qf),
    .relu_i        (params.relu),
    .y_out_ready_i (y_out_ready_i),
    .win_ready_o   (win_ready),
    .y_out_valid_o (y_out_valid_o),
    .y_out_o       (y_out_o)
  );

endmodule

// File: source/hwce_sop.sv
//////////////////////////////////////////////////////////////////////
// three-stage sum of products with fixed-point scaling,
// saturation and rectifier
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "hwce_defines.svh"

module hwce_sop (
  input  logic                       clk_fast_i,
  input  logic                       rst_n,
  input  logic                       win_valid_i,
  input  hwce_data_pkg::window_t     win_i,
  input  hwce_data_pkg::weight_set_t weights_i,
  input  logic [4:0]                 qf_i,
  input  logic                       relu_i,
  input  logic                       y_out_ready_i,
  output logic                       win_ready_o,
  output logic                       y_out_valid_o,
  output hwce_data_pkg::pixel_t      y_out_o
);
  import hwce_data_pkg::*;

  localparam acc_t SAT_MAX = acc_t'(2 ** (`HWCE_PIX_W - 1) - 1);
  localparam acc_t SAT_MIN = -acc_t'(2 ** (`HWCE_PIX_W - 1));

  logic   advance;
  logic   s1_valid_q;
  logic   s2_valid_q;
  acc_t   prod_q [`HWCE_TAPS];
  pixel_t y_q;
  acc_t   sum_d;
  acc_t   sum_q;
  acc_t   shifted;
  pixel_t result;

  // whole pipe freezes on output back-pressure
  assign advance     = ~(y_out_valid_o & ~y_out_ready_i);
  assign win_ready_o = advance;

  //////////////////////////////////////////////////////////////////////
  // stage 2: products, partial sum and bias in qf scale
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    sum_d = (acc_t'(y_q) <<< qf_i) + (acc_t'(weights_i.bias) <<< qf_i);
    for (int j = 0; j < `HWCE_TAPS; j++) begin
      sum_d = sum_d + prod_q[j];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stage 3: back to pixel scale, clamp, rectify
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    shifted = sum_q >>> qf_i;
    if (shifted > SAT_MAX) begin
      result = pixel_t'(SAT_MAX);
    end else if (shifted < SAT_MIN) begin
      result = pixel_t'(SAT_MIN);
    end else begin
      result = pixel_t'(shifted);
    end
    if (relu_i && result[`HWCE_PIX_W-1]) begin
      result = '0;
    end
  end

  always_ff @(posedge clk_fast_i or negedge rst_n) begin
    if (rst_n == 1'b0) begin
      s1_valid_q    <= 1'b0;
      s2_valid_q    <= 1'b0;
      y_out_valid_o <= 1'b0;
    end else if (advance) begin
      s1_valid_q    <= win_valid_i;
      s2_valid_q    <= s1_valid_q;
      y_out_valid_o <= s2_valid_q;
    end
  end

  always_ff @(posedge clk_fast_i) begin
    if (advance) begin
      // tap j times pixel j, full product kept
      for (int j = 0; j < `HWCE_TAPS; j++) begin
        prod_q[j] <= $signed(win_i.x[j]) * $signed(weights_i.taps[j]);
      end
      y_q     <= win_i.y;
      sum_q   <= sum_d;
      y_out_o <= result;
    end
  end

  // a stalled output must not change under the sink
  a_out_stable : assert property (@(posedge clk_fast_i) disable iff (!rst_n)
    y_out_valid_o && !y_out_ready_i |=> y_out_valid_o && $stable(y_out_o));

endmodule

// File: source/hwce_window.sv
//////////////////////////////////////////////////////////////////////
// tap shift register pairing x_in and y_in into windows
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "hwce_defines.svh"

module hwce_window (
  input  logic                   clk_fast_i,
  input  logic                   rst_n,
  input  logic                   start_i,
  input  logic                   enable_i,
  input  logic                   x_in_valid_i,
  input  hwce_data_pkg::pixel_t  x_in_i,
  input  logic                   y_in_valid_i,
  input  hwce_data_pkg::pixel_t  y_in_i,
  input  logic                   win_ready_i,
  output logic                   x_in_ready_o,
  output logic                   y_in_ready_o,
  output logic                   win_valid_o,
  output hwce_data_pkg::window_t win_o
);
  import hwce_data_pkg::*;

  pixel_t [`HWCE_TAPS-1:0] taps_q;
  pixel_t                  y_q;
  logic [2:0]              fill_q;
  logic                    filling;
  logic                    can_take;
  logic                    x_fire;

  // first TAPS-1 pixels only prime the shift register
  assign filling  = (fill_q != 3'(`HWCE_TAPS - 1));
  assign can_take = enable_i & (~win_valid_o | win_ready_i);

  // once primed, x and y move together
  assign x_in_ready_o = can_take & (filling | y_in_valid_i);
  assign y_in_ready_o = can_take & ~filling & x_in_valid_i;
  assign x_fire       = x_in_valid_i & x_in_ready_o;

  always_ff @(posedge clk_fast_i or negedge rst_n) begin
    if (rst_n == 1'b0) begin
      fill_q      <= '0;
      win_valid_o <= 1'b0;
    end else if (start_i) begin
      fill_q      <= '0;
      win_valid_o <= 1'b0;
    end else begin
      if (x_fire && filling) begin
        fill_q <= fill_q + 1'b1;
      end
      if (x_fire && !filling) begin
        win_valid_o <= 1'b1;
      end else if (win_ready_i) begin
        win_valid_o <= 1'b0;
      end
    end
  end

  // newest pixel enters at the top
  always_ff @(posedge clk_fast_i) begin
    if (x_fire) begin
      taps_q <= {x_in_i, taps_q[`HWCE_TAPS-1:1]};
    end
    if (x_fire && !filling) begin
      y_q <= y_in_i;
    end
  end

  assign win_o = '{x: taps_q, y: y_q};

endmodule

// File: source/hwce_weight_loader.sv
//////////////////////////////////////////////////////////////////////
// memory master fetching the filter taps and the bias
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "hwce_defines.svh"

module hwce_weight_loader (
  input  logic                       clk_fast_i,
  input  logic                       rst_n,
  input  logic                       start_i,
  input  hwce_data_pkg::mem_addr_t   base_i,
  input  logic                       mem_gnt_i,
  input  logic                       mem_r_valid_i,
  input  logic [`HWCE_DATA_W-1:0]    mem_rdata_i,
  output logic                       mem_req_o,
  output hwce_data_pkg::mem_addr_t   mem_addr_o,
  output hwce_data_pkg::weight_set_t weights_o,
  output logic                       done_o
);
  import hwce_data_pkg::*;

  // taps plus bias
  localparam int unsigned NWORDS = `HWCE_TAPS + 1;

  logic       active_q;
  logic [2:0] req_cnt_q;
  logic [2:0] rsp_cnt_q;
  logic       rsp_fire;
  logic       last_rsp;

  // requests run ahead of responses
  assign mem_req_o  = active_q & (req_cnt_q < NWORDS);
  assign mem_addr_o = base_i + mem_addr_t'({req_cnt_q, 2'b00});
  assign rsp_fire   = mem_r_valid_i & active_q;
  assign last_rsp   = rsp_fire & (rsp_cnt_q == NWORDS - 1);

  always_ff @(posedge clk_fast_i or negedge rst_n) begin
    if (rst_n == 1'b0) begin
      active_q  <= 1'b0;
      req_cnt_q <= '0;
      rsp_cnt_q <= '0;
      done_o    <= 1'b0;
    end else begin
      done_o <= last_rsp;
      if (start_i) begin
        active_q  <= 1'b1;
        req_cnt_q <= '0;
        rsp_cnt_q <= '0;
      end else begin
        if (mem_req_o && mem_gnt_i) begin
          req_cnt_q <= req_cnt_q + 1'b1;
        end
        if (rsp_fire) begin
          rsp_cnt_q <= rsp_cnt_q + 1'b1;
        end
        if (last_rsp) begin
          active_q <= 1'b0;
        end
      end
    end
  end

  // responses land by arrival order, low half of each word
  always_ff @(posedge clk_fast_i) begin
    if (rsp_fire) begin
      if (rsp_cnt_q == `HWCE_TAPS) begin
        weights_o.bias <= pixel_t'(mem_rdata_i[`HWCE_PIX_W-1:0]);
      end else begin
        weights_o.taps[rsp_cnt_q] <= weight_t'(mem_rdata_i[`HWCE_PIX_W-1:0]);
      end
    end
  end

  // a request burst only opens right after a start
  a_req_in_load : assert property (@(posedge clk_fast_i) disable iff (!rst_n)
    $rose(mem_req_o) |-> $past(start_i));

endmodule

// File: source/hwce_ctrl.sv
//////////////////////////////////////////////////////////////////////
// job FSM: weight load, computation and completion event
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "hwce_defines.svh"

module hwce_ctrl (
  input  logic                   clk_fast_i,
  input  logic                   rst_n,
  input  logic                   trigger_i,
  input  logic                   wl_done_i,
  input  logic                   out_fire_i,
  input  logic [`HWCE_PIX_W-1:0] x_len_i,
  output logic                   wl_start_o,
  output logic                   compute_o,
  output logic                   busy_o,
  output logic                   evt_interrupt_o
);
  import hwce_cfg_pkg::*;

  ctrl_state_t            state_q;
  ctrl_state_t            state_d;
  logic [`HWCE_PIX_W-1:0] out_cnt_q;
  logic [`HWCE_PIX_W-1:0] last_idx;
  logic                   last_out;

  assign wl_start_o      = (state_q == IDLE) & trigger_i;
  assign compute_o       = (state_q == COMPUTE);
  assign busy_o          = (state_q != IDLE);
  assign evt_interrupt_o = (state_q == DRAIN);

  // L - 4 outputs, so the last one has index L - 5
  assign last_idx = x_len_i - `HWCE_PIX_W'(`HWCE_TAPS);
  assign last_out = out_fire_i & (out_cnt_q == last_idx);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (trigger_i) state_d = LOAD;
      LOAD:    if (wl_done_i) state_d = COMPUTE;
      COMPUTE: if (last_out) state_d = DRAIN;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_fast_i or negedge rst_n) begin
    if (rst_n == 1'b0) begin
      state_q   <= IDLE;
      out_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (wl_start_o) begin
        out_cnt_q <= '0;
      end else if (compute_o && out_fire_i) begin
        out_cnt_q <= out_cnt_q + 1'b1;
      end
    end
  end

  // event follows an output transfer and lasts a single cycle
  a_evt_one_cycle : assert property (@(posedge clk_fast_i) disable iff (!rst_n)
    evt_interrupt_o |-> $past(out_fire_i) ##1 !evt_interrupt_o);

endmodule

// File: source/hwce_regfile.sv
//////////////////////////////////////////////////////////////////////
// configuration slave with job registers, trigger and status
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "hwce_defines.svh"

module hwce_regfile (
  input  logic                      clk_fast_i,
  input  logic                      rst_n,
  input  logic                      cfg_req_i,
  input  hwce_cfg_pkg::cfg_req_t    cfg_req_data_i,
  input  logic                      busy_i,
  output logic                      cfg_gnt_o,
  output logic                      cfg_r_valid_o,
  output hwce_cfg_pkg::cfg_rsp_t    cfg_rsp_o,
  output hwce_cfg_pkg::job_params_t params_o,
  output logic                      trigger_o
);
  import hwce_cfg_pkg::*;

  logic [2:0] reg_idx;
  logic       wr_en;
  cfg_rsp_t   rsp_d;

  // single-cycle grant
  assign cfg_gnt_o = cfg_req_i;
  assign reg_idx   = cfg_req_data_i.addr[4:2];
  assign wr_en     = cfg_req_i & cfg_req_data_i.we;
  assign trigger_o = wr_en & (reg_idx == `HWCE_REG_TRIGGER) & ~busy_i;

  // read mux, writes answer with zero
  always_comb begin
    rsp_d.id    = cfg_req_data_i.id;
    rsp_d.rdata = '0;
    if (!cfg_req_data_i.we) begin
      case (reg_idx)
        `HWCE_REG_STATUS: rsp_d.rdata = `HWCE_DATA_W'(busy_i);
        `HWCE_REG_WBASE:  rsp_d.rdata = params_o.wbase;
        `HWCE_REG_XLEN:   rsp_d.rdata = `HWCE_DATA_W'(params_o.x_len);
        `HWCE_REG_QF:     rsp_d.rdata = `HWCE_DATA_W'(params_o.qf);
        `HWCE_REG_FLAGS:  rsp_d.rdata = `HWCE_DATA_W'(params_o.relu);
        default:          rsp_d.rdata = '0;
      endcase
    end
  end

  // job registers, locked during a job
  always_ff @(posedge clk_fast_i or negedge rst_n) begin
    if (rst_n == 1'b0) begin
      params_o <= '0;
    end else if (wr_en && !busy_i) begin
      case (reg_idx)
        `HWCE_REG_WBASE: params_o.wbase <= cfg_req_data_i.wdata;
        `HWCE_REG_XLEN:  params_o.x_len <= cfg_req_data_i.wdata[`HWCE_PIX_W-1:0];
        `HWCE_REG_QF:    params_o.qf    <= cfg_req_data_i.wdata[4:0];
        `HWCE_REG_FLAGS: params_o.relu  <= cfg_req_data_i.wdata[0];
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_fast_i or negedge rst_n) begin
    if (rst_n == 1'b0) begin
      cfg_r_valid_o <= 1'b0;
    end else begin
      cfg_r_valid_o <= cfg_req_i;
    end
  end

  always_ff @(posedge clk_fast_i) begin
    if (cfg_req_i) begin
      cfg_rsp_o <= rsp_d;
    end
  end

  // every grant is answered on the next cycle with its own ID
  a_rsp_follows_req : assert property (@(posedge clk_fast_i) disable iff (!rst_n)
    cfg_req_i |=> cfg_r_valid_o && cfg_rsp_o.id == $past(cfg_req_data_i.id));

endmodule

// File: source/hwce_data_pkg.sv
//////////////////////////////////////////////////////////////////////
// pixel, weight and accumulator types
// weight set and convolution window
//////////////////////////////////////////////////////////////////////

`include "hwce_defines.svh"

package hwce_data_pkg;

  typedef logic signed [`HWCE_PIX_W-1:0]  pixel_t;
  typedef logic signed [`HWCE_PIX_W-1:0]  weight_t;
  typedef logic signed [`HWCE_ACC_W-1:0]  acc_t;
  typedef logic        [`HWCE_ADDR_W-1:0] mem_addr_t;

  // tap j is applied to window pixel j
  typedef struct packed {
    weight_t [`HWCE_TAPS-1:0] taps;
    pixel_t                   bias;
  } weight_set_t;

  // x[0] is the oldest pixel, y is the matching partial sum
  typedef struct packed {
    pixel_t [`HWCE_TAPS-1:0] x;
    pixel_t                  y;
  } window_t;

endpackage

// File: source/hwce_cfg_pkg.sv
//////////////////////////////////////////////////////////////////////
// configuration bus request and response structs
// job parameter set and controller state encoding
//////////////////////////////////////////////////////////////////////

`include "hwce_defines.svh"

package hwce_cfg_pkg;

  typedef struct packed {
    logic [`HWCE_ADDR_W-1:0] addr;
    logic                    we;
    logic [`HWCE_DATA_W-1:0] wdata;
    logic [`HWCE_ID_W-1:0]   id;
  } cfg_req_t;

  typedef struct packed {
    logic [`HWCE_DATA_W-1:0] rdata;
    logic [`HWCE_ID_W-1:0]   id;
  } cfg_rsp_t;

  // everything a job needs, frozen while busy
  typedef struct packed {
    logic [`HWCE_ADDR_W-1:0] wbase;
    logic [`HWCE_PIX_W-1:0]  x_len;
    logic [4:0]              qf;
    logic                    relu;
  } job_params_t;

  typedef enum logic [1:0] {IDLE, LOAD, COMPUTE, DRAIN} ctrl_state_t;

endpackage

// File: source/hwce_defines.svh
//////////////////////////////////////////////////////////////////////
// tap count, datapath and bus widths
// register word indices of the configuration port
//////////////////////////////////////////////////////////////////////

`ifndef HWCE_DEFINES_SVH
`define HWCE_DEFINES_SVH

// filter and datapath
`define HWCE_TAPS    5
`define HWCE_PIX_W   16
`define HWCE_ACC_W   40

// bus widths
`define HWCE_ADDR_W  32
`define HWCE_DATA_W  32
`define HWCE_ID_W    8

// register word index, taken from address bits 4:2
`define HWCE_REG_TRIGGER 3'd0
`define HWCE_REG_STATUS  3'd1
`define HWCE_REG_WBASE   3'd2
`define HWCE_REG_XLEN    3'd3
`define HWCE_REG_QF      3'd4
`define HWCE_REG_FLAGS   3'd5

`endif
